//--- hdl/fletcher_checksum.sv
`timescale 1ns/1ps
`default_nettype none

module fletcher_checksum
    import img_pkg::*, readout_pkg::*;
(
    input  wire        clk,
    input  wire        rst_n,
    input  wire        clear,
    input  wire        en,
    input  wire word_t din,
    output checksum_t  sum
);

    word_t sum_lo;
    word_t sum_hi;
    word_t lo_next;

    // One conditional subtract is enough since both operands stay below 2^16
    function automatic word_t add_mod(input word_t a, input word_t b);
        logic [16:0] s;
        s = {1'b0, a} + {1'b0, b};
        if (s >= 17'd65535) begin
            s = s - 17'd65535;
        end
        return s[15:0];
    endfunction

    assign lo_next = add_mod(sum_lo, din);
    assign sum = {sum_hi, sum_lo};

    always_ff @(posedge clk) begin
        if (!rst_n || clear) begin
            sum_lo <= '0;
            sum_hi <= '0;
        end else if (en) begin
            sum_lo <= lo_next;
            sum_hi <= add_mod(sum_hi, lo_next);
        end
    end

endmodule

`default_nettype wire

//--- hdl/frame_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module frame_buffer
    import img_pkg::*;
(
    input  wire            clk,
    input  wire fb_write_t wr,
    input  wire fb_block_t rd_block,
    input  wire fb_addr_t  rd_addr,
    output word_t          rd_data
);

    // Block select is the top address bit
    word_t mem [0:2*img_pixel_count-1];

    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[{wr.block, wr.addr}] <= wr.data;
        end
        rd_data <= mem[{rd_block, rd_addr}];
    end

endmodule

`default_nettype wire

//--- hdl/img_controller.sv
`timescale 1ns/1ps
`default_nettype none

module img_controller
    import img_pkg::*, readout_pkg::*;
(
    input  wire              clk,
    input  wire              rst_n,

    // Commands
    input  wire              cmd_capture,
    input  wire              cmd_readout,
    input  wire fb_block_t   cmd_ram_block,
    input  wire skip_count_t cmd_skip_count,
    input  wire header_t     cmd_header,
    input  wire              cmd_thumb,

    // Sensor
    input  wire pixel_bus_t  pixel_in,

    // Capture status
    output logic             status_capture_done,
    output capture_status_t  status,

    // Stream
    output logic             readout_start,
    output logic             readout_ready,
    input  wire              readout_trigger,
    output word_t            readout_data
);

    fb_write_t fb_wr;
    fb_block_t rd_block;
    fb_addr_t rd_addr;
    word_t rd_data;
    logic ck_clear;
    logic ck_en;
    word_t ck_din;
    checksum_t ck_sum;

    pixel_capture capture (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (cmd_capture),
        .block   (cmd_ram_block),
        .skip    (cmd_skip_count),
        .pixel_in(pixel_in),
        .wr      (fb_wr),
        .done    (status_capture_done),
        .status  (status)
    );

    frame_buffer buffer (
        .clk     (clk),
        .wr      (fb_wr),
        .rd_block(rd_block),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    fletcher_checksum checksum (
        .clk  (clk),
        .rst_n(rst_n),
        .clear(ck_clear),
        .en   (ck_en),
        .din  (ck_din),
        .sum  (ck_sum)
    );

    // Block select is latched by the sequencer on its own command
    readout_sequencer sequencer (
        .clk            (clk),
        .rst_n          (rst_n),
        .start          (cmd_readout),
        .block          (cmd_ram_block),
        .header         (cmd_header),
        .thumb          (cmd_thumb),
        .rd_block       (rd_block),
        .rd_addr        (rd_addr),
        .rd_data        (rd_data),
        .ck_clear       (ck_clear),
        .ck_en          (ck_en),
        .ck_din         (ck_din),
        .ck_sum         (ck_sum),
        .readout_start  (readout_start),
        .readout_ready  (readout_ready),
        .readout_trigger(readout_trigger),
        .readout_data   (readout_data)
    );

endmodule

`default_nettype wire

//--- hdl/img_pkg.sv
`default_nettype none

package img_pkg;

    // ========================================================================
    // Image geometry
    // ========================================================================
    localparam int img_width = 32;
    localparam int img_height = 16;
    localparam int img_pixel_count = img_width * img_height;

    // ========================================================================
    // Pixel and buffer types
    // ========================================================================
    typedef logic [11:0] pixel_t;
    typedef logic [15:0] word_t;
    typedef logic [8:0] fb_addr_t;
    typedef logic [0:0] fb_block_t;
    typedef logic [0:0] skip_count_t;
    typedef logic [17:0] stat_count_t;
    typedef logic [9:0] pixel_count_t;

    // Sensor bus as seen on clk
    typedef struct packed {
        logic fv;
        logic lv;
        pixel_t d;
    } pixel_bus_t;

    // One word into the frame buffer
    typedef struct packed {
        logic en;
        fb_block_t block;
        fb_addr_t addr;
        word_t data;
    } fb_write_t;

    typedef struct packed {
        pixel_count_t pixel_count;
        stat_count_t highlight_count;
        stat_count_t shadow_count;
    } capture_status_t;

endpackage

`default_nettype wire

//--- hdl/pixel_capture.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_capture
    import img_pkg::*;
(
    input  wire              clk,
    input  wire              rst_n,
    input  wire              start,
    input  wire fb_block_t   block,
    input  wire skip_count_t skip,
    input  wire pixel_bus_t  pixel_in,
    output fb_write_t        wr,
    output logic             done,
    output capture_status_t  status
);

    typedef enum logic [1:0] {
        cap_idle,
        cap_wait,
        cap_skip,
        cap_capture
    } capture_state_t;

    capture_state_t state;
    pixel_bus_t bus_q;
    logic fv_prev;
    logic lv_prev;
    logic fv_rise;
    logic fv_fall;
    logic lv_fall;
    logic [1:0] x;
    logic [1:0] y;
    skip_count_t skip_q;
    fb_block_t block_q;
    logic capturing;
    logic pix_write;
    logic sampled;
    logic [6:0] top_bits;

    // ========================================================================
    // Bus edges and sampling grid
    // ========================================================================
    assign fv_rise = bus_q.fv && !fv_prev;
    assign fv_fall = !bus_q.fv && fv_prev;
    assign lv_fall = !bus_q.lv && lv_prev;

    assign capturing = state == cap_capture;
    assign pix_write = capturing && bus_q.lv;
    // Statistics look at one pixel in every 4x4 tile
    assign sampled = pix_write && (x == 2'd0) && (y == 2'd0);
    assign top_bits = bus_q.d[11:5];

    always_ff @(posedge clk) begin
        bus_q <= pixel_in;
        if (start) begin
            block_q <= block;
        end

        // Little-endian word, low data byte first
        wr.block <= block_q;
        wr.addr <= fb_addr_t'(status.pixel_count);
        wr.data <= {bus_q.d[7:0], 4'b0000, bus_q.d[11:8]};

        if (!rst_n) begin
            state <= cap_idle;
            fv_prev <= 1'b0;
            lv_prev <= 1'b0;
            x <= '0;
            y <= '0;
            skip_q <= '0;
            wr.en <= 1'b0;
            done <= 1'b0;
            status <= '0;
        end else begin
            fv_prev <= bus_q.fv;
            lv_prev <= bus_q.lv;
            wr.en <= pix_write;
            done <= capturing && fv_fall;

            x <= bus_q.lv ? x + 1'b1 : 2'd0;
            if (!bus_q.fv) begin
                y <= '0;
            end else if (lv_fall) begin
                y <= y + 1'b1;
            end

            // Count follows the write, so it also serves as the address
            if (pix_write) begin
                status.pixel_count <= status.pixel_count + 1'b1;
            end
            if (sampled && top_bits == '1) begin
                status.highlight_count <= status.highlight_count + 1'b1;
            end
            if (sampled && top_bits == '0) begin
                status.shadow_count <= status.shadow_count + 1'b1;
            end

            // ================================================================
            // Capture FSM
            // ================================================================
            case (state)
                cap_wait: begin
                    if (fv_rise) begin
                        state <= cap_skip;
                    end
                end
                cap_skip: begin
                    if (skip_q != '0) begin
                        skip_q <= skip_q - 1'b1;
                        state <= cap_wait;
                    end else begin
                        state <= cap_capture;
                    end
                end
                cap_capture: begin
                    if (fv_fall) begin
                        state <= cap_idle;
                    end
                end
                default: begin
                    state <= cap_idle;
                end
            endcase

            // New command restarts from any state
            if (start) begin
                state <= cap_wait;
                skip_q <= skip;
                status <= '0;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/readout_pkg.sv
`default_nettype none

package readout_pkg;

    localparam int header_word_count = 8;
    localparam int checksum_word_count = 2;
    localparam int padding_word_count = 4;
    // Checksum and padding leave through the header shift register
    localparam int tail_word_count = checksum_word_count + padding_word_count;

    typedef logic [header_word_count*16-1:0] header_t;
    typedef logic [checksum_word_count*16-1:0] checksum_t;

    // Counts down the words of the header or of the tail
    typedef logic [$clog2(header_word_count+1)-1:0] word_count_t;

    typedef enum logic [2:0] {
        rd_idle,
        rd_start,
        rd_header,
        rd_pixel,
        rd_ck_load,
        rd_tail
    } readout_state_t;

endpackage

`default_nettype wire

//--- hdl/readout_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module readout_sequencer
    import img_pkg::*, readout_pkg::*;
(
    input  wire            clk,
    input  wire            rst_n,
    input  wire            start,
    input  wire fb_block_t block,
    input  wire header_t   header,
    input  wire            thumb,
    output fb_block_t      rd_block,
    output fb_addr_t       rd_addr,
    input  wire word_t     rd_data,
    output logic           ck_clear,
    output logic           ck_en,
    output word_t          ck_din,
    input  wire checksum_t ck_sum,
    output logic           readout_start,
    output logic           readout_ready,
    input  wire            readout_trigger,
    output word_t          readout_data
);

    localparam int col_bits = $clog2(img_width);
    localparam int line_bits = $clog2(img_height);

    readout_state_t state;
    word_count_t word_cnt;
    header_t shift_q;
    fb_block_t block_q;
    logic thumb_q;
    fb_addr_t pix_addr;
    logic [col_bits-1:0] col;
    logic [line_bits-1:0] line;

    logic adv;
    logic shifting;
    logic shift_go;
    logic keep;
    logic take;
    logic last_pixel;
    logic tail_load;

    // ========================================================================
    // Flow control and pixel selection
    // ========================================================================
    // Output register empty or drained this cycle
    assign adv = !readout_ready || readout_trigger;

    assign shifting = (state == rd_header) || (state == rd_tail);
    assign shift_go = shifting && adv && (word_cnt != '0);

    // Thumbnail keeps the top-left 2x2 of every 8x8 tile
    assign keep = !thumb_q || ((col[2:1] == 2'b00) && (line[2:1] == 2'b00));

    // Dropped pixels retire without waiting on the output register
    assign take = (state == rd_pixel) && (adv || !keep);
    assign last_pixel = pix_addr == fb_addr_t'(img_pixel_count - 1);

    // Holding the address on a stall keeps rd_data on the pixel at pix_addr
    assign rd_block = block_q;
    assign rd_addr = take ? pix_addr + 1'b1 : pix_addr;

    // All transfers are in once the output register is empty
    assign tail_load = (state == rd_ck_load) && !readout_ready;

    assign ck_clear = state == rd_start;
    assign ck_en = readout_ready && readout_trigger;
    assign ck_din = {readout_data[7:0], readout_data[15:8]};

    // ========================================================================
    // Sequencer
    // ========================================================================
    always_ff @(posedge clk) begin
        if (state == rd_idle && start) begin
            shift_q <= header;
            block_q <= block;
            thumb_q <= thumb;
        end else if (tail_load) begin
            shift_q <= {ck_sum[7:0], ck_sum[15:8], ck_sum[23:16], ck_sum[31:24],
                        {($bits(header_t) - $bits(checksum_t)){1'b0}}};
        end else if (shift_go) begin
            shift_q <= shift_q << 16;
        end

        if (shift_go) begin
            readout_data <= shift_q[$bits(header_t)-1 -: 16];
        end else if (take && keep) begin
            readout_data <= rd_data;
        end

        if (!rst_n) begin
            state <= rd_idle;
            word_cnt <= '0;
            readout_start <= 1'b0;
            readout_ready <= 1'b0;
            pix_addr <= '0;
            col <= '0;
            line <= '0;
        end else begin
            readout_start <= 1'b0;
            if (adv) begin
                readout_ready <= 1'b0;
            end

            case (state)
                rd_idle: begin
                    if (start) begin
                        state <= rd_start;
                    end
                end
                rd_start: begin
                    readout_start <= 1'b1;
                    word_cnt <= word_count_t'(header_word_count);
                    pix_addr <= '0;
                    col <= '0;
                    line <= '0;
                    state <= rd_header;
                end
                rd_header, rd_tail: begin
                    if (shift_go) begin
                        readout_ready <= 1'b1;
                        word_cnt <= word_cnt - 1'b1;
                    end else if (adv) begin
                        state <= (state == rd_header) ? rd_pixel : rd_idle;
                    end
                end
                rd_pixel: begin
                    if (take) begin
                        if (keep) begin
                            readout_ready <= 1'b1;
                        end
                        pix_addr <= pix_addr + 1'b1;
                        if (col == col_bits'(img_width - 1)) begin
                            col <= '0;
                            line <= line + 1'b1;
                        end else begin
                            col <= col + 1'b1;
                        end
                        if (last_pixel) begin
                            state <= rd_ck_load;
                        end
                    end
                end
                rd_ck_load: begin
                    if (tail_load) begin
                        word_cnt <= word_count_t'(tail_word_count);
                        state <= rd_tail;
                    end
                end
                default: begin
                    state <= rd_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+verif
hdl/img_pkg.sv
hdl/readout_pkg.sv
hdl/pixel_capture.sv
hdl/frame_buffer.sv
hdl/fletcher_checksum.sv
hdl/readout_sequencer.sv
hdl/img_controller.sv
verif/img_controller_tb.sv

//--- verif/img_tb_model.svh
`ifndef IMG_TB_MODEL_SVH
`define IMG_TB_MODEL_SVH

// ========================================================================
// Sensor frames and expected stream
// ========================================================================
pixel_t frames [0:1][0:img_pixel_count-1];
word_t exp_words [$];

// Biased so the 4x4 sample grid sees highlights and shadows
task automatic make_frame(input int slot);
    int r;
    for (int i = 0; i < img_pixel_count; i++) begin
        r = $urandom % 4;
        if (r == 0) begin
            frames[slot][i] = {7'h7f, 5'($urandom)};
        end else if (r == 1) begin
            frames[slot][i] = {7'h00, 5'($urandom)};
        end else begin
            frames[slot][i] = pixel_t'($urandom);
        end
    end
endtask

// One frame on the sensor bus, lines separated by blanking
task automatic send_frame(input int slot);
    pixel_in = '{fv: 1'b1, lv: 1'b0, d: '0};
    repeat (fv_lead) next_cycle();
    for (int line = 0; line < img_height; line++) begin
        for (int col = 0; col < img_width; col++) begin
            pixel_in.lv = 1'b1;
            pixel_in.d = frames[slot][line * img_width + col];
            next_cycle();
        end
        pixel_in.lv = 1'b0;
        pixel_in.d = '0;
        repeat (line_gap) next_cycle();
    end
    pixel_in.fv = 1'b0;
    repeat (frame_tail) next_cycle();
endtask

// Highlights and shadows over pixels on the 4x4 grid
task automatic model_stats(input int slot, output int highlights, output int shadows);
    pixel_t p;
    highlights = 0;
    shadows = 0;
    for (int line = 0; line < img_height; line += 4) begin
        for (int col = 0; col < img_width; col += 4) begin
            p = frames[slot][line * img_width + col];
            if (p[11:5] == 7'h7f) begin
                highlights++;
            end else if (p[11:5] == 7'h00) begin
                shadows++;
            end
        end
    end
endtask

// Low data byte on top, top nibble of the sample in the low byte
function automatic word_t pixel_word(input pixel_t p);
    return {p[7:0], 4'h0, p[11:8]};
endfunction

task automatic build_stream(input int slot, input logic thumb, input header_t hdr);
    int unsigned lo;
    int unsigned hi;
    logic [31:0] sum;
    word_t sw;
    exp_words.delete();
    for (int i = header_word_count - 1; i >= 0; i--) begin
        exp_words.push_back(hdr[i*16 +: 16]);
    end
    for (int line = 0; line < img_height; line++) begin
        for (int col = 0; col < img_width; col++) begin
            if (!thumb || ((col % 8) < 2 && (line % 8) < 2)) begin
                exp_words.push_back(pixel_word(frames[slot][line * img_width + col]));
            end
        end
    end

    // Fletcher-32 over byte-swapped header and pixel words
    lo = 0;
    hi = 0;
    foreach (exp_words[i]) begin
        sw = {exp_words[i][7:0], exp_words[i][15:8]};
        lo = (lo + sw) % 65535;
        hi = (hi + lo) % 65535;
    end
    sum = {hi[15:0], lo[15:0]};
    exp_words.push_back({sum[7:0], sum[15:8]});
    exp_words.push_back({sum[23:16], sum[31:24]});
    repeat (padding_word_count) exp_words.push_back(16'h0000);
endtask

`endif

//--- verif/img_controller_tb.sv
`timescale 1ns/1ps
`default_nettype none

module img_controller_tb
    import img_pkg::*, readout_pkg::*;
;

    localparam int clk_period = 20;
    localparam int drive_delay = 2;
    localparam int unsigned seed = 32'h40a9;
    localparam int fv_lead = 4;
    localparam int line_gap = 4;
    localparam int frame_tail = 12;
    localparam int frame_cycles = fv_lead + img_height * (img_width + line_gap) + frame_tail;
    localparam int test_count = 5;
    localparam int frames_per_test = 50;
    localparam int timeout_ns = test_count * frames_per_test * frame_cycles * clk_period;
    localparam int normal_trigger_pct = 60;
    localparam int heavy_trigger_pct = 25;
    localparam int idle_check_cycles = 4;

    logic clk;
    logic rst_n;
    logic cmd_capture;
    logic cmd_readout;
    fb_block_t cmd_ram_block;
    skip_count_t cmd_skip_count;
    header_t cmd_header;
    logic cmd_thumb;
    pixel_bus_t pixel_in;
    logic status_capture_done;
    capture_status_t status;
    logic readout_start;
    logic readout_ready;
    logic readout_trigger;
    word_t readout_data;

    int done_count = 0;

    img_controller UUT (
        .clk                (clk),
        .rst_n              (rst_n),
        .cmd_capture        (cmd_capture),
        .cmd_readout        (cmd_readout),
        .cmd_ram_block      (cmd_ram_block),
        .cmd_skip_count     (cmd_skip_count),
        .cmd_header         (cmd_header),
        .cmd_thumb          (cmd_thumb),
        .pixel_in           (pixel_in),
        .status_capture_done(status_capture_done),
        .status             (status),
        .readout_start      (readout_start),
        .readout_ready      (readout_ready),
        .readout_trigger    (readout_trigger),
        .readout_data       (readout_data)
    );

    initial clk = 1'b0;
    always #(clk_period / 2) clk = ~clk;

    always @(negedge clk) begin
        if (status_capture_done) begin
            done_count++;
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #drive_delay;
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s expected %0h actual %0h", name, expected, actual);
            $display("Test FAILED");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    `include "img_tb_model.svh"

    // ========================================================================
    // Capture and readout sequences
    // ========================================================================
    task automatic capture(input fb_block_t blk, input logic skip_one, input int slot,
                           input string test_name);
        int done_before;
        int highlights;
        int shadows;
        done_before = done_count;
        cmd_capture = 1'b1;
        cmd_ram_block = blk;
        cmd_skip_count = skip_one;
        next_cycle();
        cmd_capture = 1'b0;
        // Skipped frame comes from the other slot
        if (skip_one) begin
            send_frame(1 - slot);
        end
        send_frame(slot);
        model_stats(slot, highlights, shadows);
        check({test_name, " done pulses"}, done_before + 1, done_count);
        check({test_name, " pixel count"}, img_pixel_count, status.pixel_count);
        check({test_name, " highlights"}, highlights, status.highlight_count);
        check({test_name, " shadows"}, shadows, status.shadow_count);
    endtask

    task automatic read_stream(input fb_block_t blk, input logic thumb, input int slot,
                               input int trigger_pct, input string test_name);
        header_t hdr;
        int got;
        int cycles;
        hdr = {$urandom, $urandom, $urandom, $urandom};
        build_stream(slot, thumb, hdr);
        cmd_readout = 1'b1;
        cmd_ram_block = blk;
        cmd_thumb = thumb;
        cmd_header = hdr;
        got = 0;
        cycles = 0;
        // Cycle 0 is the one with the command pulse
        while (got < exp_words.size()) begin
            @(negedge clk);
            check({test_name, " readout_start"}, cycles == 2, readout_start);
            if (readout_ready && readout_trigger) begin
                check($sformatf("%s word %0d", test_name, got), exp_words[got],
                      readout_data);
                got++;
            end
            next_cycle();
            cmd_readout = 1'b0;
            readout_trigger = ($urandom % 100) < trigger_pct;
            cycles++;
        end

        // Nothing more may come out once the stream is complete
        readout_trigger = 1'b1;
        repeat (idle_check_cycles) begin
            @(negedge clk);
            check({test_name, " idle after stream"}, 0, readout_ready);
            next_cycle();
        end
        readout_trigger = 1'b0;
    endtask

    // ========================================================================
    // Main sequence
    // ========================================================================
    initial begin
        void'($urandom(seed));
        rst_n = 1'b0;
        cmd_capture = 1'b0;
        cmd_readout = 1'b0;
        cmd_ram_block = '0;
        cmd_skip_count = '0;
        cmd_header = '0;
        cmd_thumb = 1'b0;
        pixel_in = '0;
        readout_trigger = 1'b0;
        repeat (2) @(posedge clk);
        #drive_delay;
        rst_n = 1'b1;

        check("reset readout_ready", 0, readout_ready);
        check("reset readout_start", 0, readout_start);
        check("reset capture done", 0, status_capture_done);
        check("reset pixel count", 0, status.pixel_count);
        check("reset highlights", 0, status.highlight_count);
        check("reset shadows", 0, status.shadow_count);

        make_frame(0);
        capture(0, 1'b0, 0, "capture statistics");
        read_stream(0, 1'b0, 0, normal_trigger_pct, "full readout");

        make_frame(0);
        make_frame(1);
        capture(1, 1'b1, 1, "frame skip");
        read_stream(1, 1'b0, 1, normal_trigger_pct, "frame skip readout");

        // Same block again, reduced to the thumbnail
        read_stream(1, 1'b1, 1, normal_trigger_pct, "thumbnail");

        make_frame(0);
        make_frame(1);
        capture(0, 1'b0, 0, "block 0 capture");
        capture(1, 1'b0, 1, "block 1 capture");
        read_stream(0, 1'b0, 0, heavy_trigger_pct, "block 0 back-pressure");
        read_stream(1, 1'b0, 1, heavy_trigger_pct, "block 1 back-pressure");

        $display("Test OK");
        $finish;
    end

    initial begin
        #timeout_ns;
        $display("Timeout: the tests did not complete within %0d ns", timeout_ns);
        $display("Test FAILED");
        $fatal(1, "Watchdog expired");
    end

endmodule

`default_nettype wire
